/* Makefile */
TOP = msg_bus_tb

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* source/bus_interface.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_interface #(
	parameter logic [msg_bus_pkg::ADDR_W-1:0] NODE_ADDR = msg_bus_pkg::NODE0_ADDR
) (
	input wire logic clk,
	input wire logic rst_n,

	// Master bus
	input wire logic [msg_bus_pkg::DATA_W-1:0] ma_data,
	input wire logic [msg_bus_pkg::ADDR_W-1:0] ma_addr,
	input wire logic ma_data_valid,
	input wire logic ma_frame_valid,

	// Local input port
	output logic [msg_bus_pkg::DATA_W-1:0] in_frame_data,
	output logic in_frame_valid,
	output logic in_data_valid,

	// Local output port
	input wire logic [msg_bus_pkg::DATA_W-1:0] out_frame_data,
	input wire logic out_frame_valid,
	input wire logic out_frame_data_latch,
	output logic out_overflow,

	slave_bus_if.node sb
);

	logic addr_match;
	logic release_frames;

	// No input FIFO, so the master bus passes straight through when addressed
	assign addr_match = (ma_addr == NODE_ADDR);
	assign in_frame_data = ma_data;
	assign in_frame_valid = addr_match && ma_frame_valid;
	assign in_data_valid = addr_match && ma_data_valid;

	// Only a granted node may release its frames
	assign release_frames = sb.sb_latch_tail && sb.sb_grant;

	message_fifo out_fifo (
		.clk (clk),
		.rst_n (rst_n),
		.in_data (out_frame_data),
		.in_data_latch (out_frame_data_latch),
		.in_frame_valid (out_frame_valid),
		.in_data_overflow (out_overflow),
		.out_data (sb.sb_data),
		.out_data_addr (sb.sb_addr),
		.tail (sb.sb_tail),
		.out_frame_valid (sb.sb_request),
		.latch_tail (release_frames)
	);

endmodule

`default_nettype wire

/* source/message_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module message_fifo (
	input wire logic clk,
	input wire logic rst_n,

	// Write side, one frame at a time
	input wire logic [msg_bus_pkg::DATA_W-1:0] in_data,
	input wire logic in_data_latch,
	input wire logic in_frame_valid,
	output logic in_data_overflow,

	// Read side, addressed
	output logic [msg_bus_pkg::DATA_W-1:0] out_data,
	input wire logic [msg_bus_pkg::PTR_W-1:0] out_data_addr,
	output logic [msg_bus_pkg::PTR_W-1:0] tail,
	output logic out_frame_valid,
	input wire logic latch_tail
);

	logic [msg_bus_pkg::DATA_W-1:0] mem [msg_bus_pkg::FIFO_DEPTH];

	msg_bus_pkg::ptr_t wr_ptr;
	msg_bus_pkg::ptr_t tail_q;
	msg_bus_pkg::ptr_t head_q;

	logic frame_valid_q;
	logic drop_q;
	logic overflow_q;

	logic full;
	logic byte_in;
	logic frame_end;

	// Same slot but opposite lap means the memory is full
	assign full = (wr_ptr[msg_bus_pkg::IDX_W-1:0] == head_q[msg_bus_pkg::IDX_W-1:0]) &&
		(wr_ptr[msg_bus_pkg::IDX_W] != head_q[msg_bus_pkg::IDX_W]);

	assign byte_in = in_frame_valid && in_data_latch;

	// Frame ends on the falling frame-valid level
	assign frame_end = frame_valid_q && !in_frame_valid;

	// Payload store
	always_ff @(posedge clk) begin
		if (byte_in && !full && !drop_q) begin
			mem[wr_ptr[msg_bus_pkg::IDX_W-1:0]] <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			tail_q <= '0;
			head_q <= '0;
			frame_valid_q <= 1'b0;
			drop_q <= 1'b0;
			overflow_q <= 1'b0;
		end else begin
			frame_valid_q <= in_frame_valid;
			overflow_q <= 1'b0;

			if (byte_in) begin
				if (full || drop_q) begin
					// Once a byte is lost the rest of the frame is junk
					drop_q <= 1'b1;
				end else begin
					wr_ptr <= wr_ptr + msg_bus_pkg::ptr_t'(1);
				end
			end

			if (frame_end) begin
				if (drop_q) begin
					// Rewind to the last good frame
					wr_ptr <= tail_q;
					drop_q <= 1'b0;
					overflow_q <= 1'b1;
				end else begin
					tail_q <= wr_ptr;
				end
			end

			// Reader releases everything committed so far
			if (latch_tail) begin
				head_q <= tail_q;
			end
		end
	end

	assign out_data = mem[out_data_addr[msg_bus_pkg::IDX_W-1:0]];
	assign tail = tail_q;
	assign out_frame_valid = (tail_q != head_q);
	assign in_data_overflow = overflow_q;

endmodule

`default_nettype wire

/* source/msg_bus_pkg.sv */
`default_nettype none

package msg_bus_pkg;

	// Payload byte
	localparam int DATA_W = 8;

	// FIFO pointers and tails
	localparam int PTR_W = 9;

	// Bytes held per node
	localparam int FIFO_DEPTH = 16;

	// Low pointer bits that index the memory, the next bit up marks wrap
	localparam int IDX_W = $clog2(FIFO_DEPTH);

	// Master bus addressing
	localparam int ADDR_W = 8;
	localparam logic [ADDR_W-1:0] NODE0_ADDR = 8'h11;
	localparam logic [ADDR_W-1:0] NODE1_ADDR = 8'h22;

	typedef logic [PTR_W-1:0] ptr_t;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_GRANT0,
		ARB_GRANT1
	} arb_state_t;

endpackage

`default_nettype wire

/* source/msg_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module msg_bus_top (
	input wire logic clk,
	input wire logic rst_n,

	// Master bus
	input wire logic [msg_bus_pkg::DATA_W-1:0] ma_data,
	input wire logic [msg_bus_pkg::ADDR_W-1:0] ma_addr,
	input wire logic ma_data_valid,
	input wire logic ma_frame_valid,

	// Node 0 local ports
	output logic [msg_bus_pkg::DATA_W-1:0] in0_frame_data,
	output logic in0_frame_valid,
	output logic in0_data_valid,
	input wire logic [msg_bus_pkg::DATA_W-1:0] out0_data,
	input wire logic out0_data_latch,
	input wire logic out0_frame_valid,
	output logic out0_overflow,

	// Node 1 local ports
	output logic [msg_bus_pkg::DATA_W-1:0] in1_frame_data,
	output logic in1_frame_valid,
	output logic in1_data_valid,
	input wire logic [msg_bus_pkg::DATA_W-1:0] out1_data,
	input wire logic out1_data_latch,
	input wire logic out1_frame_valid,
	output logic out1_overflow,

	// Shared slave bus reader
	input wire logic [msg_bus_pkg::PTR_W-1:0] sl_addr,
	input wire logic sl_latch_tail,
	output logic [msg_bus_pkg::DATA_W-1:0] sl_data,
	output logic [msg_bus_pkg::PTR_W-1:0] sl_tail,
	output logic sl_grant_id,
	output logic sl_busy
);

	slave_bus_if node0_bus ();
	slave_bus_if node1_bus ();

	bus_interface #(.NODE_ADDR(msg_bus_pkg::NODE0_ADDR)) node0 (
		.clk (clk),
		.rst_n (rst_n),
		.ma_data (ma_data),
		.ma_addr (ma_addr),
		.ma_data_valid (ma_data_valid),
		.ma_frame_valid (ma_frame_valid),
		.in_frame_data (in0_frame_data),
		.in_frame_valid (in0_frame_valid),
		.in_data_valid (in0_data_valid),
		.out_frame_data (out0_data),
		.out_frame_valid (out0_frame_valid),
		.out_frame_data_latch (out0_data_latch),
		.out_overflow (out0_overflow),
		.sb (node0_bus)
	);

	bus_interface #(.NODE_ADDR(msg_bus_pkg::NODE1_ADDR)) node1 (
		.clk (clk),
		.rst_n (rst_n),
		.ma_data (ma_data),
		.ma_addr (ma_addr),
		.ma_data_valid (ma_data_valid),
		.ma_frame_valid (ma_frame_valid),
		.in_frame_data (in1_frame_data),
		.in_frame_valid (in1_frame_valid),
		.in_data_valid (in1_data_valid),
		.out_frame_data (out1_data),
		.out_frame_valid (out1_frame_valid),
		.out_frame_data_latch (out1_data_latch),
		.out_overflow (out1_overflow),
		.sb (node1_bus)
	);

	slave_bus_arbiter arbiter (
		.clk (clk),
		.rst_n (rst_n),
		.sl_addr (sl_addr),
		.sl_latch_tail (sl_latch_tail),
		.sl_data (sl_data),
		.sl_tail (sl_tail),
		.sl_grant_id (sl_grant_id),
		.sl_busy (sl_busy),
		.node0_bus (node0_bus),
		.node1_bus (node1_bus)
	);

endmodule

`default_nettype wire

/* source/slave_bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module slave_bus_arbiter (
	input wire logic clk,
	input wire logic rst_n,

	// Outside reader
	input wire logic [msg_bus_pkg::PTR_W-1:0] sl_addr,
	input wire logic sl_latch_tail,
	output logic [msg_bus_pkg::DATA_W-1:0] sl_data,
	output logic [msg_bus_pkg::PTR_W-1:0] sl_tail,
	output logic sl_grant_id,
	output logic sl_busy,

	slave_bus_if.arbiter node0_bus,
	slave_bus_if.arbiter node1_bus
);

	msg_bus_pkg::arb_state_t state;

	// Node granted most recently, reset to 1 so node 0 wins first
	logic last_served;

	logic grant0;
	logic grant1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= msg_bus_pkg::ARB_IDLE;
			last_served <= 1'b1;
		end else begin
			case (state)
				msg_bus_pkg::ARB_IDLE: begin
					if (node0_bus.sb_request && (!node1_bus.sb_request || last_served)) begin
						state <= msg_bus_pkg::ARB_GRANT0;
					end else if (node1_bus.sb_request) begin
						state <= msg_bus_pkg::ARB_GRANT1;
					end
				end
				msg_bus_pkg::ARB_GRANT0: begin
					if (sl_latch_tail) begin
						state <= msg_bus_pkg::ARB_IDLE;
						last_served <= 1'b0;
					end
				end
				msg_bus_pkg::ARB_GRANT1: begin
					if (sl_latch_tail) begin
						state <= msg_bus_pkg::ARB_IDLE;
						last_served <= 1'b1;
					end
				end
				default: state <= msg_bus_pkg::ARB_IDLE;
			endcase
		end
	end

	assign grant0 = (state == msg_bus_pkg::ARB_GRANT0);
	assign grant1 = (state == msg_bus_pkg::ARB_GRANT1);

	assign node0_bus.sb_grant = grant0;
	assign node1_bus.sb_grant = grant1;

	// Address and release reach the granted node only
	assign node0_bus.sb_addr = grant0 ? sl_addr : '0;
	assign node1_bus.sb_addr = grant1 ? sl_addr : '0;
	assign node0_bus.sb_latch_tail = grant0 && sl_latch_tail;
	assign node1_bus.sb_latch_tail = grant1 && sl_latch_tail;

	// Shared bus mux, idle bus reads as zero
	assign sl_data = grant0 ? node0_bus.sb_data : (grant1 ? node1_bus.sb_data : '0);
	assign sl_tail = grant0 ? node0_bus.sb_tail : (grant1 ? node1_bus.sb_tail : '0);

	assign sl_grant_id = grant1;
	assign sl_busy = grant0 || grant1;

endmodule

`default_nettype wire

/* source/slave_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface slave_bus_if;

	// Node side
	logic [msg_bus_pkg::DATA_W-1:0] sb_data;
	logic [msg_bus_pkg::PTR_W-1:0] sb_tail;
	logic sb_request;

	// Arbiter side
	logic [msg_bus_pkg::PTR_W-1:0] sb_addr;
	logic sb_grant;
	logic sb_latch_tail;

	modport node (
		output sb_data,
		output sb_tail,
		output sb_request,
		input sb_addr,
		input sb_grant,
		input sb_latch_tail
	);

	modport arbiter (
		input sb_data,
		input sb_tail,
		input sb_request,
		output sb_addr,
		output sb_grant,
		output sb_latch_tail
	);

endinterface

`default_nettype wire

/* src.f */
source/msg_bus_pkg.sv
source/slave_bus_if.sv
source/message_fifo.sv
source/bus_interface.sv
source/slave_bus_arbiter.sv
source/msg_bus_top.sv
verification/msg_bus_assertions.sv
verification/msg_bus_tb.sv

/* verification/msg_bus_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module msg_bus_assertions (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [msg_bus_pkg::DATA_W-1:0] ma_data,
	input wire logic [msg_bus_pkg::ADDR_W-1:0] ma_addr,
	input wire logic ma_data_valid,
	input wire logic ma_frame_valid,
	input wire logic [msg_bus_pkg::DATA_W-1:0] in0_frame_data,
	input wire logic in0_frame_valid,
	input wire logic in0_data_valid,
	input wire logic [msg_bus_pkg::DATA_W-1:0] in1_frame_data,
	input wire logic in1_frame_valid,
	input wire logic in1_data_valid,
	input wire logic out0_overflow,
	input wire logic out1_overflow,
	input wire logic sl_latch_tail,
	input wire logic [msg_bus_pkg::DATA_W-1:0] sl_data,
	input wire logic [msg_bus_pkg::PTR_W-1:0] sl_tail,
	input wire logic sl_grant_id,
	input wire logic sl_busy,
	input wire logic node0_request,
	input wire logic node1_request
);

	logic filter0_bad = 1'b0;
	logic filter1_bad = 1'b0;
	logic other_addr_bad = 1'b0;
	logic grant_request_bad = 1'b0;
	logic grant_hold_bad = 1'b0;
	logic release_bad = 1'b0;
	logic reset_bad = 1'b0;
	logic overflow_bad = 1'b0;
	logic failed;

	// Sticky summary of every check below
	assign failed = filter0_bad || filter1_bad || other_addr_bad || grant_request_bad ||
		grant_hold_bad || release_bad || reset_bad || overflow_bad;

	// Node 0 passes the master bus through only when addressed
	a_filter0: assert property (@(posedge clk)
		(in0_frame_valid == (ma_frame_valid && ma_addr == msg_bus_pkg::NODE0_ADDR)) &&
		(in0_data_valid == (ma_data_valid && ma_addr == msg_bus_pkg::NODE0_ADDR)) &&
		(in0_frame_data == ma_data))
	else begin
		filter0_bad = 1'b1;
		$error("node 0 filter output does not follow the master bus");
	end

	a_filter1: assert property (@(posedge clk)
		(in1_frame_valid == (ma_frame_valid && ma_addr == msg_bus_pkg::NODE1_ADDR)) &&
		(in1_data_valid == (ma_data_valid && ma_addr == msg_bus_pkg::NODE1_ADDR)) &&
		(in1_frame_data == ma_data))
	else begin
		filter1_bad = 1'b1;
		$error("node 1 filter output does not follow the master bus");
	end

	a_other_addr: assert property (@(posedge clk)
		(ma_addr != msg_bus_pkg::NODE0_ADDR && ma_addr != msg_bus_pkg::NODE1_ADDR) |->
		!(in0_frame_valid || in0_data_valid || in1_frame_valid || in1_data_valid))
	else begin
		other_addr_bad = 1'b1;
		$error("a node accepted a master bus address that is not its own");
	end

	// A granted node keeps its request until the release edge
	a_grant_request: assert property (@(posedge clk) disable iff (!rst_n)
		sl_busy |-> (sl_grant_id ? node1_request : node0_request))
	else begin
		grant_request_bad = 1'b1;
		$error("slave bus granted to a node without a request");
	end

	a_grant_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(sl_busy && !sl_latch_tail) |=> (sl_busy && $stable(sl_grant_id)))
	else begin
		grant_hold_bad = 1'b1;
		$error("grant changed without a release from the reader");
	end

	a_release_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(sl_busy && sl_latch_tail) |=> !sl_busy)
	else begin
		release_bad = 1'b1;
		$error("arbiter did not return to idle after a release");
	end

	a_reset_state: assert property (@(posedge clk)
		!rst_n |=> (!sl_busy && !node0_request && !node1_request && !out0_overflow &&
		!out1_overflow && sl_data == '0 && sl_tail == '0))
	else begin
		reset_bad = 1'b1;
		$error("outputs not cleared by reset");
	end

	// Dropped frame is flagged by a single-cycle pulse
	a_overflow_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		out1_overflow |=> !out1_overflow)
	else begin
		overflow_bad = 1'b1;
		$error("node 1 overflow held high for more than one cycle");
	end

endmodule

bind msg_bus_top msg_bus_assertions checks (
	.node0_request (node0_bus.sb_request),
	.node1_request (node1_bus.sb_request),
	.*
);

`default_nettype wire

/* verification/msg_bus_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module msg_bus_tb;

	localparam int TIMEOUT = 100;

	logic clk = 1'b0;
	logic rst_n;
	logic [msg_bus_pkg::DATA_W-1:0] ma_data;
	logic [msg_bus_pkg::ADDR_W-1:0] ma_addr;
	logic ma_data_valid;
	logic ma_frame_valid;
	logic [msg_bus_pkg::DATA_W-1:0] in0_frame_data;
	logic in0_frame_valid;
	logic in0_data_valid;
	logic [msg_bus_pkg::DATA_W-1:0] out0_data;
	logic out0_data_latch;
	logic out0_frame_valid;
	logic out0_overflow;
	logic [msg_bus_pkg::DATA_W-1:0] in1_frame_data;
	logic in1_frame_valid;
	logic in1_data_valid;
	logic [msg_bus_pkg::DATA_W-1:0] out1_data;
	logic out1_data_latch;
	logic out1_frame_valid;
	logic out1_overflow;
	logic [msg_bus_pkg::PTR_W-1:0] sl_addr;
	logic sl_latch_tail;
	logic [msg_bus_pkg::DATA_W-1:0] sl_data;
	logic [msg_bus_pkg::PTR_W-1:0] sl_tail;
	logic sl_grant_id;
	logic sl_busy;

	integer seed;

	// Expected bytes and reader head per node
	logic [msg_bus_pkg::DATA_W-1:0] frames [2][$];
	msg_bus_pkg::ptr_t head [2];

	msg_bus_top DUT (.*);

	always #2 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERROR at %0d ns: %s is %0h, expected %0h",
				$time, name, actual, expected);
			abort_run("DUT output differs from the expected value");
		end
	endtask

	task automatic drive_master(input logic [msg_bus_pkg::ADDR_W-1:0] addr, input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			ma_addr = addr;
			ma_data = msg_bus_pkg::DATA_W'($random(seed));
			ma_frame_valid = 1'b1;
			ma_data_valid = i[0];
		end
		@(negedge clk);
		ma_frame_valid = 1'b0;
		ma_data_valid = 1'b0;
	endtask

	// Frames longer than the FIFO are dropped, so they are not expected
	task automatic drive_frames(input logic to0, input logic to1, input int len);
		logic [msg_bus_pkg::DATA_W-1:0] b0;
		logic [msg_bus_pkg::DATA_W-1:0] b1;
		for (int i = 0; i < len; i++) begin
			@(negedge clk);
			b0 = msg_bus_pkg::DATA_W'($random(seed));
			b1 = msg_bus_pkg::DATA_W'($random(seed));
			out0_data = b0;
			out0_frame_valid = to0;
			out0_data_latch = to0;
			out1_data = b1;
			out1_frame_valid = to1;
			out1_data_latch = to1;
			if (to0 && len <= msg_bus_pkg::FIFO_DEPTH) frames[0].push_back(b0);
			if (to1 && len <= msg_bus_pkg::FIFO_DEPTH) frames[1].push_back(b1);
		end
		@(negedge clk);
		out0_frame_valid = 1'b0;
		out0_data_latch = 1'b0;
		out1_frame_valid = 1'b0;
		out1_data_latch = 1'b0;
	endtask

	task automatic wait_grant(input logic id);
		int cycles;
		cycles = 0;
		while (!sl_busy) begin
			if (cycles == TIMEOUT) abort_run("timed out waiting for a slave bus grant");
			@(negedge clk);
			cycles++;
		end
		check_value("sl_grant_id", 32'(sl_grant_id), 32'(id));
	endtask

	// Reads every committed byte of the granted node, then releases them
	task automatic read_frames(input logic id);
		msg_bus_pkg::ptr_t addr;
		msg_bus_pkg::ptr_t exp_tail;
		int count;
		count = frames[id].size();
		exp_tail = head[id] + msg_bus_pkg::ptr_t'(count);
		check_value("sl_tail", 32'(sl_tail), 32'(exp_tail));
		addr = head[id];
		for (int i = 0; i < count; i++) begin
			sl_addr = addr;
			@(negedge clk);
			check_value("sl_data", 32'(sl_data), 32'(frames[id][i]));
			addr++;
		end
		sl_latch_tail = 1'b1;
		@(negedge clk);
		sl_latch_tail = 1'b0;
		check_value("sl_busy", 32'(sl_busy), 32'(1'b0));
		head[id] = exp_tail;
		frames[id].delete();
	endtask

	task automatic wait_overflow();
		int cycles;
		cycles = 0;
		while (!out1_overflow) begin
			if (cycles == TIMEOUT) abort_run("timed out waiting for the node 1 overflow pulse");
			@(negedge clk);
			cycles++;
		end
	endtask

	always @(negedge clk) begin
		if (DUT.checks.failed) abort_run("a bound assertion failed");
	end

	initial begin
		seed = 32'h88a2c449;
		rst_n = 1'b0;
		ma_data = '0;
		ma_addr = '0;
		ma_data_valid = 1'b0;
		ma_frame_valid = 1'b0;
		out0_data = '0;
		out0_data_latch = 1'b0;
		out0_frame_valid = 1'b0;
		out1_data = '0;
		out1_data_latch = 1'b0;
		out1_frame_valid = 1'b0;
		sl_addr = '0;
		sl_latch_tail = 1'b0;
		head[0] = '0;
		head[1] = '0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		// Master bus filter, checked by the bound assertions
		drive_master(msg_bus_pkg::NODE0_ADDR, 6);
		drive_master(msg_bus_pkg::NODE1_ADDR, 6);
		drive_master(8'h33, 6);

		// Both nodes commit together, node 0 wins first after reset
		drive_frames(1'b1, 1'b1, 5);
		wait_grant(1'b0);
		read_frames(1'b0);
		@(negedge clk);
		check_value("sl_busy", 32'(sl_busy), 32'(1'b1));
		check_value("sl_grant_id", 32'(sl_grant_id), 32'(1'b1));
		read_frames(1'b1);

		// Single frame on node 0
		drive_frames(1'b1, 1'b0, 9);
		wait_grant(1'b0);
		read_frames(1'b0);

		// Oversized frame on node 1 is dropped
		drive_frames(1'b0, 1'b1, msg_bus_pkg::FIFO_DEPTH + 4);
		wait_overflow();
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			check_value("out1_overflow", 32'(out1_overflow), 32'(1'b0));
			check_value("node1 sb_request", 32'(DUT.node1_bus.sb_request), 32'(1'b0));
			check_value("sl_busy", 32'(sl_busy), 32'(1'b0));
		end
		drive_frames(1'b0, 1'b1, 6);
		wait_grant(1'b1);
		read_frames(1'b1);

		repeat (4) @(negedge clk);
		if (DUT.checks.failed) begin
			abort_run("a bound assertion failed");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

`default_nettype wire
